// File: verilog/rv_pkg.sv
package rv_pkg;

  ////////////////////
  // widths and reset values

  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  ////////////////////
  // major opcodes in bits [6:0] of the instruction

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111
  } opcode_e;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SRL    = 4'd3,
    ALU_SRA    = 4'd4,
    ALU_AND    = 4'd5,
    ALU_OR     = 4'd6,
    ALU_XOR    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // nine branch and jump kinds need four bits
  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_EQ   = 4'd1,
    BR_NE   = 4'd2,
    BR_LT   = 4'd3,
    BR_GE   = 4'd4,
    BR_LTU  = 4'd5,
    BR_GEU  = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } branch_e;

  // register writeback source
  typedef enum logic [1:0] {
    WB_ALU      = 2'd0,
    WB_MEM_WORD = 2'd1,
    WB_MEM_BYTE = 2'd2,
    WB_LINK     = 2'd3
  } wb_sel_e;

endpackage

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic [rv_pkg::XLEN-1:0]   instr_i,
  output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rd_addr_o,
  output logic [rv_pkg::XLEN-1:0]   imm_o,
  output rv_pkg::alu_op_e           alu_op_o,
  output rv_pkg::branch_e           branch_o,
  output rv_pkg::wb_sel_e           wb_sel_o,
  output logic                      src_a_pc_o,
  output logic                      src_b_imm_o,
  output logic                      reg_we_o,
  output logic                      mem_re_o,
  output logic                      mem_we_o,
  output logic                      store_byte_o
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  assign opcode     = rv_pkg::opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign rd_addr_o  = instr_i[11:7];

  ////////////////////
  // immediate by format
  always_comb begin
    case (opcode)
      rv_pkg::OP_LOAD, rv_pkg::OP_IMM, rv_pkg::OP_JALR:
        imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      rv_pkg::OP_STORE:
        imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      rv_pkg::OP_BRANCH:
        imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:
        imm_o = {instr_i[31:12], 12'd0};
      rv_pkg::OP_JAL:
        imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      default:
        imm_o = '0;
    endcase
  end

  ////////////////////
  // control per instruction
  always_comb begin
    // defaults so an unknown word does nothing visible
    alu_op_o     = rv_pkg::ALU_ADD;
    branch_o     = rv_pkg::BR_NONE;
    wb_sel_o     = rv_pkg::WB_ALU;
    src_a_pc_o   = 1'b0;
    src_b_imm_o  = 1'b0;
    reg_we_o     = 1'b0;
    mem_re_o     = 1'b0;
    mem_we_o     = 1'b0;
    store_byte_o = 1'b0;
    case (opcode)
      rv_pkg::OP_REG: begin
        reg_we_o = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = rv_pkg::ALU_ADD;
          10'b0100000_000: alu_op_o = rv_pkg::ALU_SUB;
          10'b0000000_001: alu_op_o = rv_pkg::ALU_SLL;
          10'b0000000_010: alu_op_o = rv_pkg::ALU_SLT;
          10'b0000000_011: alu_op_o = rv_pkg::ALU_SLTU;
          10'b0000000_100: alu_op_o = rv_pkg::ALU_XOR;
          10'b0000000_101: alu_op_o = rv_pkg::ALU_SRL;
          10'b0100000_101: alu_op_o = rv_pkg::ALU_SRA;
          10'b0000000_110: alu_op_o = rv_pkg::ALU_OR;
          10'b0000000_111: alu_op_o = rv_pkg::ALU_AND;
          default:         reg_we_o = 1'b0;
        endcase
      end
      rv_pkg::OP_IMM: begin
        reg_we_o    = 1'b1;
        src_b_imm_o = 1'b1;
        case (funct3)
          3'b000: alu_op_o = rv_pkg::ALU_ADD;
          3'b010: alu_op_o = rv_pkg::ALU_SLT;
          3'b011: alu_op_o = rv_pkg::ALU_SLTU;
          3'b100: alu_op_o = rv_pkg::ALU_XOR;
          3'b110: alu_op_o = rv_pkg::ALU_OR;
          3'b111: alu_op_o = rv_pkg::ALU_AND;
          3'b001: alu_op_o = rv_pkg::ALU_SLL;
          // srai carries funct7 bit 5 in the immediate
          3'b101: alu_op_o = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          default: reg_we_o = 1'b0;
        endcase
      end
      rv_pkg::OP_LOAD: begin
        src_b_imm_o = 1'b1;
        if (funct3 == 3'b000 || funct3 == 3'b010) begin
          reg_we_o = 1'b1;
          mem_re_o = 1'b1;
          wb_sel_o = funct3[1] ? rv_pkg::WB_MEM_WORD : rv_pkg::WB_MEM_BYTE;
        end
      end
      rv_pkg::OP_STORE: begin
        src_b_imm_o = 1'b1;
        if (funct3 == 3'b000 || funct3 == 3'b010) begin
          mem_we_o     = 1'b1;
          store_byte_o = !funct3[1];
        end
      end
      rv_pkg::OP_BRANCH: begin
        case (funct3)
          3'b000:  branch_o = rv_pkg::BR_EQ;
          3'b001:  branch_o = rv_pkg::BR_NE;
          3'b100:  branch_o = rv_pkg::BR_LT;
          3'b101:  branch_o = rv_pkg::BR_GE;
          3'b110:  branch_o = rv_pkg::BR_LTU;
          3'b111:  branch_o = rv_pkg::BR_GEU;
          default: branch_o = rv_pkg::BR_NONE;
        endcase
      end
      rv_pkg::OP_LUI: begin
        alu_op_o    = rv_pkg::ALU_PASS_B;
        src_b_imm_o = 1'b1;
        reg_we_o    = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        src_a_pc_o  = 1'b1;
        src_b_imm_o = 1'b1;
        reg_we_o    = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        branch_o = rv_pkg::BR_JAL;
        wb_sel_o = rv_pkg::WB_LINK;
        reg_we_o = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        if (funct3 == 3'b000) begin
          // target is rs1 + imm out of the alu
          src_b_imm_o = 1'b1;
          branch_o    = rv_pkg::BR_JALR;
          wb_sel_o    = rv_pkg::WB_LINK;
          reg_we_o    = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // a load and a store never share one cycle on the data port
  always_comb begin
    assert (!(mem_re_o && mem_we_o))
      else $error("decode: read and write strobes both set for %h", instr_i);
  end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  logic [rv_pkg::XLEN-1:0] rs1_i,
  input  logic [rv_pkg::XLEN-1:0] rs2_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  input  logic [rv_pkg::XLEN-1:0] imm_i,
  input  rv_pkg::alu_op_e         alu_op_i,
  input  logic                    src_a_pc_i,
  input  logic                    src_b_imm_i,
  output logic [rv_pkg::XLEN-1:0] result_o,
  output logic                    eq_o,
  output logic                    lt_o,
  output logic                    ltu_o
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;

  // operand muxes
  assign op_a  = src_a_pc_i ? pc_i : rs1_i;
  assign op_b  = src_b_imm_i ? imm_i : rs2_i;
  assign shamt = op_b[4:0];

  ////////////////////
  // operations
  always_comb begin
    case (alu_op_i)
      rv_pkg::ALU_ADD:    result_o = op_a + op_b;
      rv_pkg::ALU_SUB:    result_o = op_a - op_b;
      rv_pkg::ALU_SLL:    result_o = op_a << shamt;
      rv_pkg::ALU_SRL:    result_o = op_a >> shamt;
      rv_pkg::ALU_SRA:    result_o = $signed(op_a) >>> shamt;
      rv_pkg::ALU_AND:    result_o = op_a & op_b;
      rv_pkg::ALU_OR:     result_o = op_a | op_b;
      rv_pkg::ALU_XOR:    result_o = op_a ^ op_b;
      rv_pkg::ALU_SLT:
        result_o = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:
        result_o = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::ALU_PASS_B: result_o = op_b;
      default:            result_o = '0;
    endcase
  end

  ////////////////////
  // branch flags always on the register pair
  assign eq_o  = (rs1_i == rs2_i);
  assign lt_o  = ($signed(rs1_i) < $signed(rs2_i));
  assign ltu_o = (rs1_i < rs2_i);

endmodule

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::branch_e         branch_i,
  input  logic                    eq_i,
  input  logic                    lt_i,
  input  logic                    ltu_i,
  input  logic [rv_pkg::XLEN-1:0] imm_i,
  input  logic [rv_pkg::XLEN-1:0] alu_result_i,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic [rv_pkg::XLEN-1:0] pc_plus4_o
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic [rv_pkg::XLEN-1:0] pc_next;
  logic                    taken;

  assign pc_o       = pc_q;
  assign pc_plus4_o = pc_q + 32'd4;

  // branch resolution against the alu flags
  always_comb begin
    case (branch_i)
      rv_pkg::BR_EQ:  taken = eq_i;
      rv_pkg::BR_NE:  taken = !eq_i;
      rv_pkg::BR_LT:  taken = lt_i;
      rv_pkg::BR_GE:  taken = !lt_i;
      rv_pkg::BR_LTU: taken = ltu_i;
      rv_pkg::BR_GEU: taken = !ltu_i;
      rv_pkg::BR_JAL: taken = 1'b1;
      default:        taken = 1'b0;
    endcase
  end

  // jalr clears bit 0 of rs1 + imm
  always_comb begin
    if (branch_i == rv_pkg::BR_JALR) begin
      pc_next = {alu_result_i[rv_pkg::XLEN-1:1], 1'b0};
    end else if (taken) begin
      pc_next = pc_q + imm_i;
    end else begin
      pc_next = pc_plus4_o;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= rv_pkg::RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // no target in the program may land off a word boundary
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00)
    else $error("fetch: misaligned pc %h", pc_q);

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::REG_AW-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_AW-1:0] rs2_addr_i,
  input  logic [rv_pkg::REG_AW-1:0] rd_addr_i,
  input  logic                      we_i,
  input  logic [rv_pkg::XLEN-1:0]   rd_data_i,
  output logic [rv_pkg::XLEN-1:0]   rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]   rs2_data_o
);

  logic [rv_pkg::XLEN-1:0] regs_q [rv_pkg::NUM_REGS];

  // asynchronous read ports
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_addr_i != '0) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1_addr_i == '0) |-> (rs1_data_o == '0))
    else $error("regfile: x0 reads %h", rs1_data_o);

endmodule

// File: verilog/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
  input  logic [rv_pkg::XLEN-1:0] rs2_i,
  input  logic [rv_pkg::XLEN-1:0] alu_result_i,
  input  logic [rv_pkg::XLEN-1:0] pc_plus4_i,
  input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
  input  logic                    store_byte_i,
  input  logic                    mem_re_i,
  input  logic                    mem_we_i,
  input  rv_pkg::wb_sel_e         wb_sel_i,
  output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
  output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
  output logic                    dmem_re_o,
  output logic                    dmem_we_o,
  output logic [rv_pkg::XLEN-1:0] rd_data_o
);

  logic [rv_pkg::XLEN-1:0] load_byte;

  ////////////////////
  // data port side
  assign dmem_addr_o = alu_result_i;
  assign dmem_re_o   = mem_re_i;
  assign dmem_we_o   = mem_we_i;

  // sb writes the low byte zero extended into the whole word
  assign dmem_wdata_o = store_byte_i ? {{(rv_pkg::XLEN-8){1'b0}}, rs2_i[7:0]} : rs2_i;

  // lb returns the low byte zero extended
  assign load_byte = {{(rv_pkg::XLEN-8){1'b0}}, dmem_rdata_i[7:0]};

  ////////////////////
  // writeback select
  always_comb begin
    case (wb_sel_i)
      rv_pkg::WB_MEM_WORD: rd_data_o = dmem_rdata_i;
      rv_pkg::WB_MEM_BYTE: rd_data_o = load_byte;
      rv_pkg::WB_LINK:     rd_data_o = pc_plus4_i;
      default:             rd_data_o = alu_result_i;
    endcase
  end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  output logic [rv_pkg::XLEN-1:0] imem_addr_o,
  input  logic [rv_pkg::XLEN-1:0] imem_data_i,
  output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
  output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
  output logic                    dmem_we_o,
  output logic                    dmem_re_o,
  input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i
);

  logic [rv_pkg::REG_AW-1:0] rs1_addr;
  logic [rv_pkg::REG_AW-1:0] rs2_addr;
  logic [rv_pkg::REG_AW-1:0] rd_addr;
  logic [rv_pkg::XLEN-1:0]   imm;
  rv_pkg::alu_op_e           alu_op;
  rv_pkg::branch_e           branch;
  rv_pkg::wb_sel_e           wb_sel;
  logic                      src_a_pc;
  logic                      src_b_imm;
  logic                      reg_we;
  logic                      mem_re;
  logic                      mem_we;
  logic                      store_byte;

  logic [rv_pkg::XLEN-1:0]   rs1_data;
  logic [rv_pkg::XLEN-1:0]   rs2_data;
  logic [rv_pkg::XLEN-1:0]   rd_data;
  logic [rv_pkg::XLEN-1:0]   alu_result;
  logic                      eq;
  logic                      lt;
  logic                      ltu;
  logic [rv_pkg::XLEN-1:0]   pc;
  logic [rv_pkg::XLEN-1:0]   pc_plus4;

  // fetch address is the current pc
  assign imem_addr_o = pc;

  rv_decode u_decode (
    .instr_i(imem_data_i), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rd_addr_o(rd_addr), .imm_o(imm), .alu_op_o(alu_op), .branch_o(branch),
    .wb_sel_o(wb_sel), .src_a_pc_o(src_a_pc), .src_b_imm_o(src_b_imm),
    .reg_we_o(reg_we), .mem_re_o(mem_re), .mem_we_o(mem_we), .store_byte_o(store_byte)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rd_addr_i(rd_addr), .we_i(reg_we), .rd_data_i(rd_data),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  rv_alu u_alu (
    .rs1_i(rs1_data), .rs2_i(rs2_data), .pc_i(pc), .imm_i(imm), .alu_op_i(alu_op),
    .src_a_pc_i(src_a_pc), .src_b_imm_i(src_b_imm), .result_o(alu_result),
    .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
  );

  rv_fetch u_fetch (
    .clk(clk), .rst(rst), .branch_i(branch), .eq_i(eq), .lt_i(lt), .ltu_i(ltu),
    .imm_i(imm), .alu_result_i(alu_result), .pc_o(pc), .pc_plus4_o(pc_plus4)
  );

  rv_lsu u_lsu (
    .rs2_i(rs2_data), .alu_result_i(alu_result), .pc_plus4_i(pc_plus4),
    .dmem_rdata_i(dmem_rdata_i), .store_byte_i(store_byte), .mem_re_i(mem_re),
    .mem_we_i(mem_we), .wb_sel_i(wb_sel), .dmem_addr_o(dmem_addr_o),
    .dmem_wdata_o(dmem_wdata_o), .dmem_re_o(dmem_re_o), .dmem_we_o(dmem_we_o),
    .rd_data_o(rd_data)
  );

endmodule

// File: include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

////////////////////
// instruction encoders

function automatic logic [31:0] r_type(input logic [9:0] f7f3, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [4:0] rd);
  return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// funct7 and funct3 of the ten register ops in store order
function automatic logic [9:0] rop_fields(input int k);
  case (k)
    0: return 10'b0000000_000;
    1: return 10'b0100000_000;
    2: return 10'b0000000_001;
    3: return 10'b0000000_010;
    4: return 10'b0000000_011;
    5: return 10'b0000000_100;
    6: return 10'b0000000_101;
    7: return 10'b0100000_101;
    8: return 10'b0000000_110;
    default: return 10'b0000000_111;
  endcase
endfunction

// immediate and funct3 of the nine immediate ops
function automatic logic [14:0] iop_fields(input int k);
  case (k)
    0: return {12'hf3c, 3'b000};
    1: return {12'hf3c, 3'b010};
    2: return {12'hf3c, 3'b011};
    3: return {12'hf3c, 3'b100};
    4: return {12'hf3c, 3'b110};
    5: return {12'hf3c, 3'b111};
    6: return {12'h007, 3'b001};
    7: return {12'h007, 3'b101};
    default: return {12'h407, 3'b101};
  endcase
endfunction

// {funct3, rs1, rs2} with x10 holding -1 and x11 holding 1
function automatic logic [12:0] br_fields(input int j, input logic taken);
  case (j)
    0: return taken ? {3'b000, 5'd10, 5'd10} : {3'b000, 5'd10, 5'd11};
    1: return taken ? {3'b001, 5'd10, 5'd11} : {3'b001, 5'd10, 5'd10};
    2: return taken ? {3'b100, 5'd10, 5'd11} : {3'b100, 5'd11, 5'd10};
    3: return taken ? {3'b101, 5'd11, 5'd10} : {3'b101, 5'd10, 5'd11};
    4: return taken ? {3'b110, 5'd11, 5'd10} : {3'b110, 5'd10, 5'd11};
    default: return taken ? {3'b111, 5'd10, 5'd11} : {3'b111, 5'd11, 5'd10};
  endcase
endfunction

////////////////////
// program table

function automatic logic [31:0] prog_word(input int idx);
  int k;
  logic [9:0]  rf;
  logic [14:0] imf;
  logic [12:0] bf;
  logic [31:0] w;
  w = 32'h0000_0013;
  if (idx >= 4 && idx < 24) begin
    k = (idx - 4) / 2;
    rf = rop_fields(k);
    if (idx % 2 == 0) w = r_type(rf, 5'd2, 5'd1, 5'd3);
    else w = s_type(12'(128 + 4 * k), 5'd3, 5'd0, 3'b010);
  end else if (idx >= 24 && idx < 42) begin
    k = (idx - 24) / 2;
    imf = iop_fields(k);
    if (idx % 2 == 0) w = i_type(imf[14:3], 5'd1, imf[2:0], 5'd3, 7'b0010011);
    else w = s_type(12'(128 + 4 * (k + 10)), 5'd3, 5'd0, 3'b010);
  end else if (idx >= 57 && idx < 81) begin
    // taken branch, skipped filler, not-taken branch, filler
    k = (idx - 57) / 4;
    case ((idx - 57) % 4)
      0: begin
        bf = br_fields(k, 1'b1);
        w = b_type(13'd8, bf[4:0], bf[9:5], bf[12:10]);
      end
      2: begin
        bf = br_fields(k, 1'b0);
        w = b_type(13'd8, bf[4:0], bf[9:5], bf[12:10]);
      end
      default: w = 32'h0000_0013;
    endcase
  end else begin
    case (idx)
      0:  w = i_type(12'hfff, 5'd0, 3'b000, 5'd10, 7'b0010011);
      1:  w = i_type(12'h001, 5'd0, 3'b000, 5'd11, 7'b0010011);
      2:  w = i_type(12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011);
      3:  w = i_type(12'h004, 5'd0, 3'b010, 5'd2, 7'b0000011);
      42: w = i_type(12'h000, 5'd0, 3'b000, 5'd4, 7'b0000011);
      43: w = s_type(12'h0cc, 5'd4, 5'd0, 3'b010);
      44: w = s_type(12'h0d0, 5'd2, 5'd0, 3'b000);
      45: w = {20'h12345, 5'd5, 7'b0110111};
      46: w = s_type(12'h0d4, 5'd5, 5'd0, 3'b010);
      47: w = {20'h00001, 5'd6, 7'b0010111};
      48: w = s_type(12'h0d8, 5'd6, 5'd0, 3'b010);
      49: w = j_type(21'd8, 5'd7);
      51: w = s_type(12'h0dc, 5'd7, 5'd0, 3'b010);
      52: w = i_type(12'h0dd, 5'd0, 3'b000, 5'd8, 7'b0010011);
      // target 0xe1 with bit 0 cleared lands on word 56
      53: w = i_type(12'h004, 5'd8, 3'b000, 5'd9, 7'b1100111);
      56: w = s_type(12'h0e0, 5'd9, 5'd0, 3'b010);
      81: w = j_type(21'd0, 5'd0);
      default: w = 32'h0000_0013;
    endcase
  end
  return w;
endfunction

////////////////////
// expected values

function automatic logic [31:0] next_addr(input logic [31:0] pc);
  int idx;
  idx = int'(pc[31:2]);
  if (idx >= 57 && idx < 81 && (idx - 57) % 4 == 0) return pc + 32'd8;
  case (idx)
    49: return 32'd204;
    53: return 32'd224;
    81: return pc;
    default: return pc + 32'd4;
  endcase
endfunction

// value each store must write by its slot above 0x80
function automatic logic [31:0] ref_store(input logic [31:0] addr, input logic [31:0] a,
                                          input logic [31:0] b);
  logic [31:0] imm;
  logic [31:0] r;
  int k;
  imm = 32'hffff_ff3c;
  k = int'((addr - 32'h80) >> 2);
  case (k)
    0:  r = a + b;
    1:  r = a - b;
    2:  r = a << b[4:0];
    3:  r = {31'd0, $signed(a) < $signed(b)};
    4:  r = {31'd0, a < b};
    5:  r = a ^ b;
    6:  r = a >> b[4:0];
    7:  r = $signed(a) >>> b[4:0];
    8:  r = a | b;
    9:  r = a & b;
    10: r = a + imm;
    11: r = {31'd0, $signed(a) < $signed(imm)};
    12: r = {31'd0, a < imm};
    13: r = a ^ imm;
    14: r = a | imm;
    15: r = a & imm;
    16: r = a << 7;
    17: r = a >> 7;
    18: r = $signed(a) >>> 7;
    19: r = {24'd0, a[7:0]};
    20: r = {24'd0, b[7:0]};
    21: r = 32'h1234_5000;
    // auipc sits at word 47
    22: r = 32'h1000 + 32'd188;
    // jal link from word 49 and jalr link from word 53
    23: r = 32'd200;
    24: r = 32'd216;
    default: r = 32'h0;
  endcase
  return r;
endfunction

`endif

// File: bench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  `include "tb_program.svh"

  localparam logic [31:0] LOOP_PC = 32'd324;
  localparam int NUM_STORES = 25;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic        dmem_re;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [128];
  logic [31:0] dmem [64];
  logic [31:0] seed_a;
  logic [31:0] seed_b;
  logic [31:0] prev_addr;
  logic        prev_valid;
  int          errors;
  int          stores;

  rv_core u_dut (
    .clk(clk), .rst(rst), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
    .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
    .dmem_re_o(dmem_re), .dmem_rdata_i(dmem_rdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic is_store_at(input logic [31:0] pc);
    logic [31:0] w;
    w = imem[pc[8:2]];
    return w[6:0] == 7'b0100011;
  endfunction

  ////////////////////
  // memory models
  assign imem_data  = imem[imem_addr[8:2]];

  // data only comes back while the read level is up
  assign dmem_rdata = dmem_re ? dmem[dmem_addr[7:2]] : 32'h0;

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
  end

  // address of the instruction that just retired
  always @(posedge clk) begin
    prev_addr  <= imem_addr;
    prev_valid <= !rst;
  end

  always @(negedge clk) begin
    if (!rst && dmem_we) stores++;
  end

  ////////////////////
  // checks sampled mid cycle
  a_reset_pc: assert property (@(negedge clk) (!rst && !prev_valid) |-> imem_addr == 32'h0)
    else begin
      errors++;
      $display("[FAIL] imem_addr_o %h expected %h after reset", imem_addr, 32'h0);
    end

  a_next_pc: assert property (@(negedge clk) disable iff (rst)
    prev_valid |-> imem_addr == next_addr(prev_addr))
    else begin
      errors++;
      $display("[FAIL] imem_addr_o %h expected %h", imem_addr, next_addr(prev_addr));
    end

  a_store_data: assert property (@(negedge clk) disable iff (rst)
    dmem_we |-> dmem_wdata == ref_store(dmem_addr, seed_a, seed_b))
    else begin
      errors++;
      $display("[FAIL] dmem_wdata_o %h expected %h at %h", dmem_wdata,
               ref_store(dmem_addr, seed_a, seed_b), dmem_addr);
    end

  a_strobes: assert property (@(negedge clk) disable iff (rst) !(dmem_we && dmem_re))
    else begin
      errors++;
      $display("[FAIL] dmem_we_o %h dmem_re_o %h both set", dmem_we, dmem_re);
    end

  a_we_store: assert property (@(negedge clk) disable iff (rst)
    dmem_we |-> is_store_at(imem_addr))
    else begin
      errors++;
      $display("[FAIL] dmem_we_o %h on non-store at %h", dmem_we, imem_addr);
    end

  ////////////////////
  // main sequence
  initial begin
    logic [31:0] state;
    int cycles;
    rst = 1'b1;
    errors = 0;
    stores = 0;
    prev_valid = 1'b0;
    prev_addr = 32'h0;
    for (int i = 0; i < 128; i++) imem[i] = prog_word(i);
    state = 32'h35d0;
    for (int i = 0; i < 64; i++) begin
      state = lcg_next(state);
      dmem[i] = state;
    end
    seed_a = dmem[0];
    seed_b = dmem[1];

    repeat (10) @(posedge clk);
    #1 rst = 1'b0;

    cycles = 0;
    while (imem_addr != LOOP_PC && cycles < 500) begin
      @(negedge clk);
      cycles++;
    end
    if (imem_addr != LOOP_PC) begin
      errors++;
      $display("timeout: the program never reached its final loop");
    end
    // let the loop spin a few times
    repeat (3) @(posedge clk);
    if (stores != NUM_STORES) begin
      errors++;
      $display("saw %0d stores where the program has %0d", stores, NUM_STORES);
    end

    $display("summary: %0d stores seen, %0d errors", stores, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
bench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

RTL_SRCS := $(wildcard verilog/*.sv)
TB_SRCS  := bench/tb_core.sv include/tb_program.svh
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): vlog.f $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
